//--- vic_regs_settings.svh
`ifndef VIC_REGS_SETTINGS_SVH
`define VIC_REGS_SETTINGS_SVH

// register bus widths
`define VIC_ADDR_W 6
`define VIC_DATA_W 8

// colour nibble and raster line widths
`define VIC_COLOR_W 4
`define VIC_RASTER_W 9

// screen control reset values
`define VIC_YSCROLL_RST 3'd3
`define VIC_DEN_RST 1'b1

// value seen on dbo for unmapped addresses and after reset
`define VIC_UNMAPPED_READ 8'hFF

`endif

//--- vic_regs_pkg.sv
`default_nettype none

`include "vic_regs_settings.svh"

package vic_regs_pkg;

        // kept register addresses
        typedef enum logic [`VIC_ADDR_W-1:0] {
                REG_SCREEN_CTRL1 = 6'h11,
                REG_RASTER       = 6'h12,
                REG_LPX          = 6'h13,
                REG_LPY          = 6'h14,
                REG_SCREEN_CTRL2 = 6'h16,
                REG_MEM_SETUP    = 6'h18,
                REG_IRQ_STATUS   = 6'h19,
                REG_IRQ_CTRL     = 6'h1a,
                REG_BORDER       = 6'h20,
                REG_BG0          = 6'h21,
                REG_BG1          = 6'h22,
                REG_BG2          = 6'h23,
                REG_BG3          = 6'h24
        } reg_addr_e;

        // one data byte, seen through each register layout
        typedef union packed {
                struct packed {
                        logic       rst8;
                        logic       ecm;
                        logic       bmm;
                        logic       den;
                        logic       rsel;
                        logic [2:0] yscroll;
                } ctrl1;
                struct packed {
                        logic [1:0] unused;
                        logic       res;
                        logic       mcm;
                        logic       csel;
                        logic [2:0] xscroll;
                } ctrl2;
                struct packed {
                        logic [3:0] vm;
                        logic [2:0] cb;
                        logic       unused;
                } mem;
                struct packed {
                        logic [3:0] unused;
                        logic       lp;
                        logic       mmc;
                        logic       mbc;
                        logic       rst;
                } irq;
                struct packed {
                        logic [3:0]              unused;
                        logic [`VIC_COLOR_W-1:0] color;
                } color;
        } data_byte_u;

        // one bus access as the register blocks see it
        typedef struct packed {
                logic       rd;
                logic       wr;
                reg_addr_e  addr;
                data_byte_u wdata;
        } bus_op_t;

        typedef struct packed {
                logic [2:0]               xscroll;
                logic [2:0]               yscroll;
                logic                     csel;
                logic                     rsel;
                logic                     den;
                logic                     bmm;
                logic                     ecm;
                logic                     res;
                logic                     mcm;
                logic [`VIC_RASTER_W-1:0] raster_irq_compare;
                logic [2:0]               cb;
                logic [3:0]               vm;
        } screen_ctrl_t;

        typedef struct packed {
                logic [`VIC_COLOR_W-1:0] ec;
                logic [`VIC_COLOR_W-1:0] b0c;
                logic [`VIC_COLOR_W-1:0] b1c;
                logic [`VIC_COLOR_W-1:0] b2c;
                logic [`VIC_COLOR_W-1:0] b3c;
        } colors_t;

        // same bit order as the 0x19 and 0x1a low nibble
        typedef struct packed {
                logic lp;
                logic mmc;
                logic mbc;
                logic rst;
        } irq_flags_t;

endpackage

`default_nettype wire

//--- vic_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_regs_settings.svh"

module vic_bus_decode (
        input  wire                      clk_dot4x,
        input  wire                      rst,
        input  wire                      aec,
        input  wire                      ce,
        input  wire                      rw,
        input  wire                      phi_phase_start_dav,
        input  wire [`VIC_ADDR_W-1:0]    adi,
        input  wire [`VIC_DATA_W-1:0]    dbi,
        output vic_regs_pkg::bus_op_t    bus
);
        import vic_regs_pkg::*;

        logic access;
        logic rd_done;

        // chip selected and bus owned by the cpu
        assign access = aec && !ce;

        // only the first cycle of a read access counts
        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        rd_done <= 1'b0;
                end else if (!access) begin
                        rd_done <= 1'b0;
                end else if (bus.rd) begin
                        rd_done <= 1'b1;
                end
        end

        always_comb begin
                bus.rd    = access && rw && !rd_done;
                // writes land on the data-valid strobe
                bus.wr    = access && !rw && phi_phase_start_dav;
                bus.addr  = reg_addr_e'(adi);
                bus.wdata = dbi;
        end

        // dav is a single-cycle strobe, one write per access
        a_wr_single: assert property (@(posedge clk_dot4x) disable iff (rst)
                bus.wr |=> !bus.wr);

endmodule

`default_nettype wire

//--- vic_screen_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_regs_settings.svh"

module vic_screen_regs (
        input  wire                           clk_dot4x,
        input  wire                           rst,
        input  wire vic_regs_pkg::bus_op_t    bus,
        output vic_regs_pkg::screen_ctrl_t    screen
);
        import vic_regs_pkg::*;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        screen         <= '0;
                        screen.yscroll <= `VIC_YSCROLL_RST;
                        screen.den     <= `VIC_DEN_RST;
                end else if (bus.wr) begin
                        case (bus.addr)
                                REG_SCREEN_CTRL1: begin
                                        screen.yscroll <= bus.wdata.ctrl1.yscroll;
                                        screen.rsel    <= bus.wdata.ctrl1.rsel;
                                        screen.den     <= bus.wdata.ctrl1.den;
                                        screen.bmm     <= bus.wdata.ctrl1.bmm;
                                        screen.ecm     <= bus.wdata.ctrl1.ecm;
                                        // compare bit 8 lives in 0x11
                                        screen.raster_irq_compare[8] <= bus.wdata.ctrl1.rst8;
                                end
                                REG_RASTER: begin
                                        screen.raster_irq_compare[7:0] <= bus.wdata;
                                end
                                REG_SCREEN_CTRL2: begin
                                        screen.xscroll <= bus.wdata.ctrl2.xscroll;
                                        screen.csel    <= bus.wdata.ctrl2.csel;
                                        screen.mcm     <= bus.wdata.ctrl2.mcm;
                                        screen.res     <= bus.wdata.ctrl2.res;
                                end
                                REG_MEM_SETUP: begin
                                        screen.cb <= bus.wdata.mem.cb;
                                        screen.vm <= bus.wdata.mem.vm;
                                end
                                default: begin
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- vic_color_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_regs_settings.svh"

module vic_color_regs (
        input  wire                           clk_dot4x,
        input  wire                           rst,
        input  wire vic_regs_pkg::bus_op_t    bus,
        output vic_regs_pkg::colors_t         colors
);
        import vic_regs_pkg::*;

        // only the low nibble of each colour byte is kept
        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        colors <= '0;
                end else if (bus.wr) begin
                        case (bus.addr)
                                REG_BORDER: colors.ec  <= bus.wdata.color.color;
                                REG_BG0:    colors.b0c <= bus.wdata.color.color;
                                REG_BG1:    colors.b1c <= bus.wdata.color.color;
                                REG_BG2:    colors.b2c <= bus.wdata.color.color;
                                REG_BG3:    colors.b3c <= bus.wdata.color.color;
                                default: begin
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- vic_irq_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_regs_settings.svh"

module vic_irq_regs (
        input  wire                           clk_dot4x,
        input  wire                           rst,
        input  wire                           clk_phi,
        input  wire                           phi_phase_start_15,
        input  wire vic_regs_pkg::bus_op_t    bus,
        output vic_regs_pkg::irq_flags_t      irq_en,
        output vic_regs_pkg::irq_flags_t      irq_clr
);
        import vic_regs_pkg::*;

        logic phase_end;
        logic clr_wr;

        // last step of the high phase
        assign phase_end = phi_phase_start_15 && clk_phi;
        assign clr_wr    = bus.wr && (bus.addr == REG_IRQ_STATUS);

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        irq_en  <= '0;
                        irq_clr <= '0;
                end else begin
                        if (phase_end) begin
                                irq_clr <= '0;
                        end
                        // a write in the same cycle overrides the drop
                        if (clr_wr) begin
                                irq_clr.rst <= bus.wdata.irq.rst;
                                irq_clr.mbc <= bus.wdata.irq.mbc;
                                irq_clr.mmc <= bus.wdata.irq.mmc;
                                irq_clr.lp  <= bus.wdata.irq.lp;
                        end
                        if (bus.wr && (bus.addr == REG_IRQ_CTRL)) begin
                                irq_en.rst <= bus.wdata.irq.rst;
                                irq_en.mbc <= bus.wdata.irq.mbc;
                                irq_en.mmc <= bus.wdata.irq.mmc;
                                irq_en.lp  <= bus.wdata.irq.lp;
                        end
                end
        end

        // ack writes only arrive in the high phase
        a_clr_in_high: assert property (@(posedge clk_dot4x) disable iff (rst)
                clr_wr |-> clk_phi);

endmodule

`default_nettype wire

//--- vic_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_regs_settings.svh"

module vic_read_mux (
        input  wire                              clk_dot4x,
        input  wire                              rst,
        input  wire vic_regs_pkg::bus_op_t       bus,
        input  wire vic_regs_pkg::screen_ctrl_t  screen,
        input  wire vic_regs_pkg::colors_t       colors,
        input  wire vic_regs_pkg::irq_flags_t    irq_en,
        input  wire vic_regs_pkg::irq_flags_t    irq_flags,
        input  wire                              irq,
        input  wire [`VIC_RASTER_W-1:0]          raster_line,
        input  wire [`VIC_DATA_W-1:0]            lpx,
        input  wire [`VIC_DATA_W-1:0]            lpy,
        output logic [`VIC_DATA_W-1:0]           dbo
);
        import vic_regs_pkg::*;

        data_byte_u rd_byte;

        // start from all ones so unused bits read back high
        always_comb begin
                rd_byte = `VIC_UNMAPPED_READ;
                case (bus.addr)
                        REG_SCREEN_CTRL1: begin
                                rd_byte.ctrl1.yscroll = screen.yscroll;
                                rd_byte.ctrl1.rsel    = screen.rsel;
                                rd_byte.ctrl1.den     = screen.den;
                                rd_byte.ctrl1.bmm     = screen.bmm;
                                rd_byte.ctrl1.ecm     = screen.ecm;
                                // live line, not the compare value
                                rd_byte.ctrl1.rst8    = raster_line[8];
                        end
                        REG_RASTER: rd_byte = raster_line[7:0];
                        REG_LPX:    rd_byte = lpx;
                        REG_LPY:    rd_byte = lpy;
                        REG_SCREEN_CTRL2: begin
                                rd_byte.ctrl2.xscroll = screen.xscroll;
                                rd_byte.ctrl2.csel    = screen.csel;
                                rd_byte.ctrl2.mcm     = screen.mcm;
                                rd_byte.ctrl2.res     = screen.res;
                        end
                        REG_MEM_SETUP: begin
                                rd_byte.mem.cb = screen.cb;
                                rd_byte.mem.vm = screen.vm;
                        end
                        REG_IRQ_STATUS: begin
                                rd_byte.irq.rst = irq_flags.rst;
                                rd_byte.irq.mbc = irq_flags.mbc;
                                rd_byte.irq.mmc = irq_flags.mmc;
                                rd_byte.irq.lp  = irq_flags.lp;
                                rd_byte[7]      = irq;
                        end
                        REG_IRQ_CTRL: begin
                                rd_byte.irq.rst = irq_en.rst;
                                rd_byte.irq.mbc = irq_en.mbc;
                                rd_byte.irq.mmc = irq_en.mmc;
                                rd_byte.irq.lp  = irq_en.lp;
                        end
                        REG_BORDER: rd_byte.color.color = colors.ec;
                        REG_BG0:    rd_byte.color.color = colors.b0c;
                        REG_BG1:    rd_byte.color.color = colors.b1c;
                        REG_BG2:    rd_byte.color.color = colors.b2c;
                        REG_BG3:    rd_byte.color.color = colors.b3c;
                        default: begin
                        end
                endcase
        end

        // held until the next read strobe
        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        dbo <= `VIC_UNMAPPED_READ;
                end else if (bus.rd) begin
                        dbo <= rd_byte;
                end
        end

endmodule

`default_nettype wire

//--- vic_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_regs_settings.svh"

module vic_regs_top (
        input  wire                              clk_dot4x,
        input  wire                              rst,
        input  wire                              clk_phi,
        input  wire                              phi_phase_start_15,
        input  wire                              phi_phase_start_dav,
        input  wire                              ce,
        input  wire                              rw,
        input  wire                              aec,
        input  wire [`VIC_ADDR_W-1:0]            adi,
        input  wire [`VIC_DATA_W-1:0]            dbi,
        input  wire [`VIC_RASTER_W-1:0]          raster_line,
        input  wire [`VIC_DATA_W-1:0]            lpx,
        input  wire [`VIC_DATA_W-1:0]            lpy,
        input  wire                              irq,
        input  wire vic_regs_pkg::irq_flags_t    irq_flags,
        output logic [`VIC_DATA_W-1:0]           dbo,
        output vic_regs_pkg::screen_ctrl_t       screen,
        output vic_regs_pkg::colors_t            colors,
        output vic_regs_pkg::irq_flags_t         irq_en,
        output vic_regs_pkg::irq_flags_t         irq_clr
);
        import vic_regs_pkg::*;

        bus_op_t bus;

        vic_bus_decode decode_i (
                .clk_dot4x           (clk_dot4x),
                .rst                 (rst),
                .aec                 (aec),
                .ce                  (ce),
                .rw                  (rw),
                .phi_phase_start_dav (phi_phase_start_dav),
                .adi                 (adi),
                .dbi                 (dbi),
                .bus                 (bus)
        );

        vic_screen_regs screen_i (
                .clk_dot4x (clk_dot4x),
                .rst       (rst),
                .bus       (bus),
                .screen    (screen)
        );

        vic_color_regs color_i (
                .clk_dot4x (clk_dot4x),
                .rst       (rst),
                .bus       (bus),
                .colors    (colors)
        );

        vic_irq_regs irq_i (
                .clk_dot4x          (clk_dot4x),
                .rst                (rst),
                .clk_phi            (clk_phi),
                .phi_phase_start_15 (phi_phase_start_15),
                .bus                (bus),
                .irq_en             (irq_en),
                .irq_clr            (irq_clr)
        );

        vic_read_mux read_i (
                .clk_dot4x   (clk_dot4x),
                .rst         (rst),
                .bus         (bus),
                .screen      (screen),
                .colors      (colors),
                .irq_en      (irq_en),
                .irq_flags   (irq_flags),
                .irq         (irq),
                .raster_line (raster_line),
                .lpx         (lpx),
                .lpy         (lpy),
                .dbo         (dbo)
        );

endmodule

`default_nettype wire

//--- tb_vic_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "vic_regs_settings.svh"

module tb_vic_regs;
        import vic_regs_pkg::*;

        localparam integer N_RANDOM    = 40;
        localparam integer N_UNMAPPED  = 10;
        localparam integer N_STATUS    = 20;
        localparam integer N_IRQ       = 8;
        localparam integer N_ACCESSES  = 13 + 2 * N_RANDOM + 2 * N_UNMAPPED + N_STATUS + 3 * N_IRQ;
        localparam integer WATCHDOG_NS = (N_ACCESSES + 20) * 32 * 8;

        logic                     clk_dot4x = 1'b0;
        logic                     rst;
        logic [4:0]               phi_step = 5'd0;
        logic                     clk_phi;
        logic                     phi_phase_start_15;
        logic                     phi_phase_start_dav;
        logic                     ce;
        logic                     rw;
        logic                     aec;
        logic [`VIC_ADDR_W-1:0]   adi;
        logic [`VIC_DATA_W-1:0]   dbi;
        logic [`VIC_RASTER_W-1:0] raster_line;
        logic [`VIC_DATA_W-1:0]   lpx;
        logic [`VIC_DATA_W-1:0]   lpy;
        logic                     irq;
        irq_flags_t               irq_flags;
        logic [`VIC_DATA_W-1:0]   dbo;
        screen_ctrl_t             screen;
        colors_t                  colors;
        irq_flags_t               irq_en;
        irq_flags_t               irq_clr;

        // model of the written register bytes
        logic [7:0]               m_d011;
        logic [7:0]               m_d012;
        logic [7:0]               m_d016;
        logic [7:0]               m_d018;
        logic [7:0]               m_d01a;
        logic [3:0]               m_col [0:4];
        logic [7:0]               last_dbo;
        integer                   seed;
        integer                   read_errors;
        integer                   output_errors;
        integer                   i;
        string                    test_name;

        vic_regs_top dut_i (
                .clk_dot4x           (clk_dot4x),
                .rst                 (rst),
                .clk_phi             (clk_phi),
                .phi_phase_start_15  (phi_phase_start_15),
                .phi_phase_start_dav (phi_phase_start_dav),
                .ce                  (ce),
                .rw                  (rw),
                .aec                 (aec),
                .adi                 (adi),
                .dbi                 (dbi),
                .raster_line         (raster_line),
                .lpx                 (lpx),
                .lpy                 (lpy),
                .irq                 (irq),
                .irq_flags           (irq_flags),
                .dbo                 (dbo),
                .screen              (screen),
                .colors              (colors),
                .irq_en              (irq_en),
                .irq_clr             (irq_clr)
        );

        always #4 clk_dot4x = ~clk_dot4x;

        // 32 dot4x cycles per phi cycle, low half first
        always @(negedge clk_dot4x) begin
                phi_step <= phi_step + 5'd1;
        end

        assign clk_phi             = phi_step[4];
        assign phi_phase_start_15  = (phi_step[3:0] == 4'd15);
        assign phi_phase_start_dav = (phi_step == 5'd21);

        function automatic logic is_kept(input logic [5:0] addr);
                case (addr)
                        6'h11, 6'h12, 6'h13, 6'h14, 6'h16, 6'h18, 6'h19, 6'h1a,
                        6'h20, 6'h21, 6'h22, 6'h23, 6'h24: return 1'b1;
                        default: return 1'b0;
                endcase
        endfunction

        // read layout, unused bits padded with ones
        function automatic logic [7:0] expected_read(input logic [5:0] addr);
                logic [7:0] b;
                b = `VIC_UNMAPPED_READ;
                case (addr)
                        6'h11: b = {raster_line[8], m_d011[6:0]};
                        6'h12: b = raster_line[7:0];
                        6'h13: b = lpx;
                        6'h14: b = lpy;
                        6'h16: b = {2'b11, m_d016[5:0]};
                        6'h18: b = {m_d018[7:1], 1'b1};
                        6'h19: b = {irq, 3'b111, irq_flags};
                        6'h1a: b = {4'hF, m_d01a[3:0]};
                        6'h20, 6'h21, 6'h22, 6'h23, 6'h24: b = {4'hF, m_col[addr[2:0]]};
                        default: b = `VIC_UNMAPPED_READ;
                endcase
                return b;
        endfunction

        function automatic screen_ctrl_t expected_screen();
                screen_ctrl_t s;
                s.yscroll            = m_d011[2:0];
                s.rsel               = m_d011[3];
                s.den                = m_d011[4];
                s.bmm                = m_d011[5];
                s.ecm                = m_d011[6];
                s.raster_irq_compare = {m_d011[7], m_d012};
                s.xscroll            = m_d016[2:0];
                s.csel               = m_d016[3];
                s.mcm                = m_d016[4];
                s.res                = m_d016[5];
                s.cb                 = m_d018[3:1];
                s.vm                 = m_d018[7:4];
                return s;
        endfunction

        function automatic colors_t expected_colors();
                colors_t c;
                c.ec  = m_col[0];
                c.b0c = m_col[1];
                c.b1c = m_col[2];
                c.b2c = m_col[3];
                c.b3c = m_col[4];
                return c;
        endfunction

        task automatic model_write(input logic [5:0] addr, input logic [7:0] data);
                case (addr)
                        6'h11: m_d011 = data;
                        6'h12: m_d012 = data;
                        6'h16: m_d016 = data;
                        6'h18: m_d018 = data;
                        6'h1a: m_d01a = data;
                        6'h20, 6'h21, 6'h22, 6'h23, 6'h24: m_col[addr[2:0]] = data[3:0];
                        default: begin
                        end
                endcase
        endtask

        task automatic check_value(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val, input logic is_read);
                if (exp_val !== act_val) begin
                        $display("ERROR %s %s: expected %0h, actual %0h",
                                 test_name, what, exp_val, act_val);
                        if (is_read) begin
                                read_errors = read_errors + 1;
                        end else begin
                                output_errors = output_errors + 1;
                        end
                end
        endtask

        task automatic check_outputs(input logic [3:0] exp_clr);
                check_value("screen", expected_screen(), screen, 1'b0);
                check_value("colors", expected_colors(), colors, 1'b0);
                check_value("irq_en", {28'd0, m_d01a[3:0]}, irq_en, 1'b0);
                check_value("irq_clr", {28'd0, exp_clr}, irq_clr, 1'b0);
        endtask

        task automatic randomize_status();
                logic [31:0] r;
                r           = $random(seed);
                raster_line = r[8:0];
                lpx         = r[16:9];
                lpy         = r[24:17];
                irq         = r[25];
                irq_flags   = r[29:26];
        endtask

        task automatic pick_addr(input logic want_kept, output logic [5:0] addr);
                logic [31:0] r;
                r    = $random(seed);
                addr = r[5:0];
                while (is_kept(addr) != want_kept) begin
                        r    = $random(seed);
                        addr = r[5:0];
                end
        endtask

        // one access over the whole high phase of phi
        task automatic bus_access(input logic is_read, input logic [5:0] addr,
                                  input logic [7:0] data);
                logic [7:0] exp_dbo;
                integer     k;
                @(posedge clk_dot4x);
                while (phi_step != 5'd15) begin
                        @(posedge clk_dot4x);
                end
                @(negedge clk_dot4x);
                aec = 1'b1;
                ce  = 1'b0;
                rw  = is_read;
                adi = addr;
                dbi = data;
                if (is_read) begin
                        randomize_status();
                        exp_dbo = expected_read(addr);
                end else begin
                        model_write(addr, data);
                        exp_dbo = last_dbo;
                end
                for (k = 17; k < 32; k = k + 1) begin
                        @(negedge clk_dot4x);
                        if (k == 17) begin
                                check_value("dbo", exp_dbo, dbo, 1'b1);
                        end
                        // write landed on the dav edge at step 21
                        if (k == 22 && !is_read) begin
                                check_outputs(addr == 6'h19 ? data[3:0] : 4'h0);
                        end
                        // status keeps moving while the read is held
                        if (is_read) begin
                                randomize_status();
                        end
                end
                @(negedge clk_dot4x);
                aec = 1'b0;
                ce  = 1'b1;
                rw  = 1'b1;
                check_value("dbo held", exp_dbo, dbo, 1'b1);
                check_value("irq_clr dropped", 32'd0, irq_clr, 1'b0);
                last_dbo = exp_dbo;
        endtask

        initial begin
                logic [5:0]  addr;
                logic [31:0] r;
                seed          = 32'hda43;
                read_errors   = 0;
                output_errors = 0;
                rst           = 1'b1;
                aec           = 1'b0;
                ce            = 1'b1;
                rw            = 1'b1;
                adi           = '0;
                dbi           = '0;
                raster_line   = '0;
                lpx           = '0;
                lpy           = '0;
                irq           = 1'b0;
                irq_flags     = '0;
                m_d011        = {3'b000, `VIC_DEN_RST, 1'b0, `VIC_YSCROLL_RST};
                m_d012        = 8'h00;
                m_d016        = 8'h00;
                m_d018        = 8'h00;
                m_d01a        = 8'h00;
                for (i = 0; i < 5; i = i + 1) begin
                        m_col[i] = 4'h0;
                end
                last_dbo      = `VIC_UNMAPPED_READ;

                test_name = "reset";
                repeat (8) @(negedge clk_dot4x);
                rst = 1'b0;
                @(negedge clk_dot4x);
                check_value("dbo after reset", `VIC_UNMAPPED_READ, dbo, 1'b1);
                check_outputs(4'h0);
                for (i = 0; i < 64; i = i + 1) begin
                        if (is_kept(i[5:0])) begin
                                bus_access(1'b1, i[5:0], 8'h00);
                        end
                end

                test_name = "random_rw";
                for (i = 0; i < N_RANDOM; i = i + 1) begin
                        pick_addr(1'b1, addr);
                        r = $random(seed);
                        bus_access(1'b0, addr, r[7:0]);
                        bus_access(1'b1, addr, 8'h00);
                end

                test_name = "unmapped";
                for (i = 0; i < N_UNMAPPED; i = i + 1) begin
                        pick_addr(1'b0, addr);
                        r = $random(seed);
                        bus_access(1'b0, addr, r[7:0]);
                        bus_access(1'b1, addr, 8'h00);
                end

                test_name = "status_reads";
                for (i = 0; i < N_STATUS; i = i + 1) begin
                        r = $unsigned($random(seed)) % 5;
                        case (r)
                                0: addr = 6'h11;
                                1: addr = 6'h12;
                                2: addr = 6'h13;
                                3: addr = 6'h14;
                                default: addr = 6'h19;
                        endcase
                        bus_access(1'b1, addr, 8'h00);
                end

                test_name = "irq";
                for (i = 0; i < N_IRQ; i = i + 1) begin
                        r = $random(seed);
                        bus_access(1'b0, 6'h19, r[7:0]);
                        bus_access(1'b0, 6'h1a, r[15:8]);
                        bus_access(1'b1, 6'h1a, 8'h00);
                end

                $display("errors: %0d read, %0d output", read_errors, output_errors);
                if (read_errors + output_errors == 0) begin
                        $display("TEST OK");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

        // watchdog sized from the number of bus accesses
        initial begin
                #(WATCHDOG_NS);
                $display("timeout: the bus accesses did not complete in time");
                $display("TEST FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- vic_regs_top.f
+incdir+.
vic_regs_pkg.sv
vic_bus_decode.sv
vic_screen_regs.sv
vic_color_regs.sv
vic_irq_regs.sv
vic_read_mux.sv
vic_regs_top.sv
tb_vic_regs.sv
